// File: src/neuron_params.svh
`ifndef NEURON_PARAMS_SVH
`define NEURON_PARAMS_SVH

// ----------------------------------------
// vector geometry
// ----------------------------------------

`define NEURON_NUM_INPUTS 187	// samples per vector and weights in the bank
`define NEURON_INDEX_WIDTH 8	// wide enough to address the bias after the last weight

// ----------------------------------------
// arithmetic
// ----------------------------------------

`define NEURON_WORD_WIDTH 32	// samples, weights and the running sum all share this width

// the rectified output keeps only this slice of the sum
`define NEURON_OUT_MSB 28
`define NEURON_OUT_LSB 13

`endif

// File: src/neuronPkg.sv
package neuronPkg;

`include "neuron_params.svh"

	// ----------------------------------------
	// datapath types
	// ----------------------------------------

	typedef logic signed [`NEURON_WORD_WIDTH-1:0] wordT;	// products wrap at this width
	typedef logic [`NEURON_INDEX_WIDTH-1:0] indexT;

	// ----------------------------------------
	// sequencer
	// ----------------------------------------

	typedef enum logic
	{
		SEQ_IDLE,	// waiting for the first sample of a vector
		SEQ_ACCUM	// some samples of the vector have been taken
	} seqStateT;

endpackage

// File: src/neuronStepIf.sv
`timescale 1ns/1ps

interface neuronStepIf;
	import neuronPkg::*;

	logic accept;	// a sample is taken on this edge
	indexT index;	// position of that sample in the vector
	logic first;
	logic last;
	logic sumReady;	// accumulator holds a complete sum this cycle

	modport seq
	(
		output accept,
		output index,
		output first,
		output last,
		output sumReady
	);

	modport bank (input index);

	modport mac (input accept, input first);

	modport act (input sumReady);

endinterface

// File: src/neuronSequencer.sv
`timescale 1ns/1ps
`include "neuron_params.svh"

module neuronSequencer
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	neuronStepIf.seq step
);
	import neuronPkg::*;

	localparam indexT LAST_INDEX = indexT'(`NEURON_NUM_INPUTS - 1);

	seqStateT state;
	indexT count;

	// ----------------------------------------
	// step strobes
	// ----------------------------------------

	assign step.accept = sampleValid;	// every strobe is taken since there is no back-pressure
	assign step.index = count;
	assign step.first = (state == SEQ_IDLE);
	assign step.last = (count == LAST_INDEX);

	// ----------------------------------------
	// sample counter and state
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			count <= '0;
			step.sumReady <= 1'b0;
		end
		else
		begin
			step.sumReady <= step.accept && step.last;	// sum lands in the accumulator on this edge
			if (step.accept)
			begin
				if (step.last)
				begin
					state <= SEQ_IDLE;	// next sample may open a new vector at once
					count <= '0;
				end
				else
				begin
					state <= SEQ_ACCUM;
					count <= count + 1'b1;
				end
			end
		end
	end

	// the counter must wrap before it leaves the weight range
	indexInRange: assert property (@(posedge clk) disable iff (reset)
		step.accept |-> step.index <= LAST_INDEX)
		else $error("sample index %0d beyond the last weight", step.index);

endmodule

// File: src/neuronWeightBank.sv
`timescale 1ns/1ps
`include "neuron_params.svh"

module neuronWeightBank
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input neuronPkg::indexT cfgAddr,
	input neuronPkg::wordT cfgData,
	neuronStepIf.bank step,
	output neuronPkg::wordT weight,
	output neuronPkg::wordT bias
);
	import neuronPkg::*;

	localparam indexT BIAS_ADDR = indexT'(`NEURON_NUM_INPUTS);	// bias sits right after the weights

	wordT weights [`NEURON_NUM_INPUTS];

	// ----------------------------------------
	// configuration writes
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NEURON_NUM_INPUTS; i++)
			begin
				weights[i] <= '0;
			end
			bias <= '0;
		end
		else if (cfgWrite)
		begin
			if (cfgAddr == BIAS_ADDR)
			begin
				bias <= cfgData;
			end
			else if (cfgAddr < BIAS_ADDR)
			begin
				weights[cfgAddr] <= cfgData;
			end
		end
	end

	assign weight = weights[step.index];	// follows the sequencer index in the same cycle

	cfgAddrInRange: assert property (@(posedge clk) disable iff (reset)
		cfgWrite |-> cfgAddr <= BIAS_ADDR)
		else $error("configuration write to unmapped address %0d", cfgAddr);

endmodule

// File: src/neuronMac.sv
`timescale 1ns/1ps

module neuronMac
(
	input logic clk,
	input logic reset,
	input neuronPkg::wordT sampleData,
	input neuronPkg::wordT weight,
	input neuronPkg::wordT bias,
	neuronStepIf.mac step,
	output neuronPkg::wordT sum
);
	import neuronPkg::*;

	wordT product;
	wordT base;

	// ----------------------------------------
	// multiply and select the addend
	// ----------------------------------------

	assign product = sampleData * weight;	// only the low word is kept so the sum wraps

	// a new vector starts from the bias instead of the old sum
	assign base = step.first ? bias : sum;

	// ----------------------------------------
	// accumulator
	// ----------------------------------------

	// the sample is registered straight into the running sum on its accept edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sum <= '0;
		end
		else if (step.accept)
		begin
			sum <= base + product;
		end
	end

endmodule

// File: src/neuronActivation.sv
`timescale 1ns/1ps
`include "neuron_params.svh"

module neuronActivation
(
	input logic clk,
	input logic reset,
	input neuronPkg::wordT sum,
	neuronStepIf.act step,
	output logic resultValid,
	output neuronPkg::wordT result
);
	import neuronPkg::*;

	localparam int SLICE_WIDTH = `NEURON_OUT_MSB - `NEURON_OUT_LSB + 1;

	logic [SLICE_WIDTH-1:0] slice;
	logic negative;

	assign slice = sum[`NEURON_OUT_MSB:`NEURON_OUT_LSB];
	assign negative = sum[`NEURON_WORD_WIDTH-1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			result <= '0;
		end
		else
		begin
			resultValid <= step.sumReady;	// one cycle pulse per finished vector
			if (step.sumReady)
			begin
				result <= negative ? '0 : wordT'(slice);	// rectifier then zero-extended slice
			end
		end
	end

	upperBitsClear: assert property (@(posedge clk) disable iff (reset)
		result[`NEURON_WORD_WIDTH-1:SLICE_WIDTH] == '0)
		else $error("result has bits set above the output slice");

endmodule

// File: src/neuronTop.sv
`timescale 1ns/1ps

module neuronTop
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input neuronPkg::indexT cfgAddr,
	input neuronPkg::wordT cfgData,
	input logic sampleValid,
	input neuronPkg::wordT sampleData,
	output logic resultValid,
	output neuronPkg::wordT result
);
	import neuronPkg::*;

	wordT weight;
	wordT bias;
	wordT sum;

	neuronStepIf step();

	// ----------------------------------------
	// control
	// ----------------------------------------

	neuronSequencer sequencer
	(
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.step(step.seq)
	);

	// ----------------------------------------
	// datapath
	// ----------------------------------------

	neuronWeightBank weightBank
	(
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.step(step.bank),
		.weight(weight),
		.bias(bias)
	);

	neuronMac mac
	(
		.clk(clk),
		.reset(reset),
		.sampleData(sampleData),
		.weight(weight),
		.bias(bias),
		.step(step.mac),
		.sum(sum)
	);

	// captures the old sum on the edge where the accumulator may already reload
	neuronActivation activation
	(
		.clk(clk),
		.reset(reset),
		.sum(sum),
		.step(step.act),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

// File: tests/neuronTb.sv
`timescale 1ns/1ps
`include "neuron_params.svh"

module neuronTb;
	import neuronPkg::*;

	localparam int NUM_VECTORS = 8;
	localparam int WATCHDOG_CYCLES = 2 * NUM_VECTORS * 250;
	localparam int N = `NEURON_NUM_INPUTS;

	logic clk;
	logic reset;
	logic cfgWrite;
	indexT cfgAddr;
	wordT cfgData;
	logic sampleValid;
	wordT sampleData;
	logic resultValid;
	wordT result;

	logic lastSample;	// marks the strobe that carries the last sample of a vector
	int seed = 47861;
	int errorCount = 0;
	int pushCount = 0;
	int checkCount;

	wordT weightsModel [N];
	wordT biasModel;
	wordT samples [N];
	wordT expectedQ [$];

	neuronTop DUT
	(
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.resultValid(resultValid),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	function automatic wordT modelResult();
		wordT acc;
		wordT rectified;
		acc = biasModel;
		for (int i = 0; i < N; i++)
		begin
			acc = acc + samples[i] * weightsModel[i];	// wraps at the word width
		end
		rectified = '0;
		if (!acc[`NEURON_WORD_WIDTH-1])
		begin
			rectified[`NEURON_OUT_MSB-`NEURON_OUT_LSB:0] = acc[`NEURON_OUT_MSB:`NEURON_OUT_LSB];
		end
		return rectified;
	endfunction

	// small signed values keep the sum well inside the positive range
	function automatic wordT randomByte();
		logic [31:0] r;
		r = $random(seed);
		return wordT'($signed(r[7:0]));
	endfunction

	// ----------------------------------------
	// stimulus tasks
	// ----------------------------------------

	task automatic writeConfig(input int addr, input wordT data);
		@(posedge clk);
		cfgWrite <= 1'b1;
		cfgAddr <= indexT'(addr);
		cfgData <= data;
		if (addr == N)
			biasModel = data;
		else
			weightsModel[addr] = data;
	endtask

	task automatic endConfig();
		@(posedge clk);
		cfgWrite <= 1'b0;
	endtask

	task automatic fillSamples(input bit zeros);
		for (int i = 0; i < N; i++)
		begin
			samples[i] = zeros ? '0 : randomByte();
		end
	endtask

	// leaves sampleValid high after the last sample so a following vector can start at once
	task automatic sendVector(input bit withGaps);
		logic [31:0] r;
		wordT expected;
		expected = modelResult();
		for (int i = 0; i < N; i++)
		begin
			if (withGaps)
			begin
				r = $random(seed);
				repeat (int'(r[0]))
				begin
					@(posedge clk);
					sampleValid <= 1'b0;
					lastSample <= 1'b0;
				end
			end
			@(posedge clk);
			sampleValid <= 1'b1;
			sampleData <= samples[i];
			lastSample <= (i == N - 1);
			if (i == N - 1)
			begin
				expectedQ.push_back(expected);
				pushCount++;
			end
		end
	endtask

	task automatic endSamples();
		@(posedge clk);
		sampleValid <= 1'b0;
		lastSample <= 1'b0;
	endtask

	// ----------------------------------------
	// checking
	// ----------------------------------------

	always @(posedge clk)
	begin
		if (reset)
			checkCount <= 0;
		else if (resultValid)
			checkCount <= checkCount + 1;
	end

	resetClears: assert property (@(posedge clk) $fell(reset) |-> !resultValid && result == '0)
		else
		begin
			errorCount++;
			$display("ERROR at %0t: outputs not cleared by reset", $time);
		end

	resultMatches: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> checkCount < pushCount && result == expectedQ[checkCount])
		else
		begin
			errorCount++;
			$display("ERROR at %0t: result %0h, model expects %0h", $time,
				$sampled(result), expectedQ[$sampled(checkCount)]);
		end

	resultOnTime: assert property (@(posedge clk) disable iff (reset)
		sampleValid && lastSample |-> ##2 resultValid)
		else
		begin
			errorCount++;
			$display("ERROR at %0t: no result two cycles after the last sample", $time);
		end

	noStrayResult: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> $past(sampleValid && lastSample, 2))
		else
		begin
			errorCount++;
			$display("ERROR at %0t: result pulse without a last sample two cycles before", $time);
		end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before all expected results arrived");
		$display("Result: FAILED");
		$finish;
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------

	initial
	begin
		reset = 1'b1;
		cfgWrite = 1'b0;
		cfgAddr = '0;
		cfgData = '0;
		sampleValid = 1'b0;
		sampleData = '0;
		lastSample = 1'b0;
		biasModel = '0;
		for (int i = 0; i < N; i++)
		begin
			weightsModel[i] = '0;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// unconfigured bank gives zero
		repeat (10) @(posedge clk);
		fillSamples(1'b0);
		sendVector(1'b0);
		endSamples();

		// random weights with a positive bias
		for (int i = 0; i < N; i++)
		begin
			writeConfig(i, randomByte());
		end
		writeConfig(N, 32'h0100_0000 + (randomByte() & 32'hff));
		endConfig();
		fillSamples(1'b0);
		sendVector(1'b0);
		endSamples();

		writeConfig(N, 32'hF000_0000);	// sum goes negative
		endConfig();
		fillSamples(1'b0);
		sendVector(1'b0);
		endSamples();

		writeConfig(N, 32'h1234_5678);	// bias alone reaches the output
		endConfig();
		fillSamples(1'b1);
		sendVector(1'b0);
		endSamples();

		// back to back vectors
		writeConfig(N, 32'h0080_0000);
		endConfig();
		fillSamples(1'b0);
		sendVector(1'b0);
		fillSamples(1'b0);
		sendVector(1'b0);
		endSamples();

		// same vector with and without gaps
		fillSamples(1'b0);
		sendVector(1'b0);
		endSamples();
		sendVector(1'b1);
		endSamples();

		while (checkCount != pushCount) @(posedge clk);
		repeat (4) @(posedge clk);
		$display("results checked: %0d of %0d, errors: %0d", checkCount, pushCount, errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+src
src/neuronPkg.sv
src/neuronStepIf.sv
src/neuronSequencer.sv
src/neuronWeightBank.sv
src/neuronMac.sv
src/neuronActivation.sv
src/neuronTop.sv
tests/neuronTb.sv

// File: Makefile
# Verilator build and run for the neuron testbench

VERILATOR ?= verilator
TOP ?= neuronTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) src/*.sv src/*.svh tests/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(EXE)
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
